// File: logic/rv_isa_pkg.sv
package rv_isa_pkg;

   localparam int data_width  = 32;
   localparam int adder_width = data_width + 1; // one extra bit for the sign

   // major opcodes
   localparam logic [6:0] opc_op     = 7'b0110011;
   localparam logic [6:0] opc_op_imm = 7'b0010011;
   localparam logic [6:0] opc_lui    = 7'b0110111;
   localparam logic [6:0] opc_auipc  = 7'b0010111;
   localparam logic [6:0] opc_branch = 7'b1100011;
   localparam logic [6:0] opc_jal    = 7'b1101111;
   localparam logic [6:0] opc_jalr   = 7'b1100111;

   // funct3 of the ALU group
   localparam logic [2:0] f3_add  = 3'b000; // also sub
   localparam logic [2:0] f3_sll  = 3'b001;
   localparam logic [2:0] f3_slt  = 3'b010;
   localparam logic [2:0] f3_sltu = 3'b011;
   localparam logic [2:0] f3_xor  = 3'b100;
   localparam logic [2:0] f3_sr   = 3'b101; // srl or sra
   localparam logic [2:0] f3_or   = 3'b110;
   localparam logic [2:0] f3_and  = 3'b111;

   // funct3 of the branch group
   localparam logic [2:0] f3_beq  = 3'b000;
   localparam logic [2:0] f3_bne  = 3'b001;
   localparam logic [2:0] f3_blt  = 3'b100;
   localparam logic [2:0] f3_bge  = 3'b101;
   localparam logic [2:0] f3_bltu = 3'b110;
   localparam logic [2:0] f3_bgeu = 3'b111;

   localparam logic [6:0] f7_alt = 7'b0100000; // sub, sra

endpackage

// File: logic/ex_pkg.sv
package ex_pkg;

   localparam int alu_op_width = 10;

   // bit positions in the one-hot alu operation
   localparam int op_add  = 0;
   localparam int op_sub  = 1;
   localparam int op_xor  = 2;
   localparam int op_sll  = 3;
   localparam int op_srl  = 4;
   localparam int op_sra  = 5;
   localparam int op_or   = 6;
   localparam int op_and  = 7;
   localparam int op_slt  = 8;
   localparam int op_sltu = 9;

   // branch kinds
   localparam logic [3:0] br_none = 4'd0;
   localparam logic [3:0] br_eq   = 4'd1;
   localparam logic [3:0] br_ne   = 4'd2;
   localparam logic [3:0] br_lt   = 4'd3;
   localparam logic [3:0] br_ge   = 4'd4;
   localparam logic [3:0] br_ltu  = 4'd5;
   localparam logic [3:0] br_geu  = 4'd6;
   localparam logic [3:0] br_jal  = 4'd7;
   localparam logic [3:0] br_jalr = 4'd8;

   localparam logic res_alu  = 1'b0;
   localparam logic res_link = 1'b1; // pc + 4 for jumps

endpackage

// File: logic/uop_if.sv
`timescale 1ns/1ps

interface uop_if;

   logic                                  valid;
   logic [ex_pkg::alu_op_width-1:0]       alu_op;  // one-hot, zero when unused
   logic [rv_isa_pkg::data_width-1:0]     src_a;
   logic [rv_isa_pkg::data_width-1:0]     src_b;
   logic [rv_isa_pkg::data_width-1:0]     rs1_val;
   logic [rv_isa_pkg::data_width-1:0]     rs2_val;
   logic [rv_isa_pkg::data_width-1:0]     pc;
   logic [rv_isa_pkg::data_width-1:0]     imm;
   logic [3:0]                            br_kind;
   logic                                  res_sel;
   logic [4:0]                            rd;
   logic                                  rd_we;

   modport dec (output valid, alu_op, src_a, src_b, rs1_val, rs2_val, pc, imm,
                br_kind, res_sel, rd, rd_we);
   modport alu (input alu_op, src_a, src_b);
   modport br  (input br_kind, rs1_val, rs2_val, pc, imm);
   modport wb  (input valid, res_sel, rd, rd_we);

endinterface

// File: logic/ex_decoder.sv
`timescale 1ns/1ps

module ex_decoder (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              in_valid,
   input  logic [31:0]                       instr,
   input  logic [rv_isa_pkg::data_width-1:0] pc,
   input  logic [rv_isa_pkg::data_width-1:0] rs1_data,
   input  logic [rv_isa_pkg::data_width-1:0] rs2_data,
   uop_if.dec                                uop
);

   logic [6:0]                          opcode;
   logic [2:0]                          funct3;
   logic                                alt;
   logic [31:0]                         imm_i;
   logic [31:0]                         imm_u;
   logic [31:0]                         imm_b;
   logic [31:0]                         imm_j;
   logic [ex_pkg::alu_op_width-1:0]     d_alu_op;
   logic [rv_isa_pkg::data_width-1:0]   d_src_a;
   logic [rv_isa_pkg::data_width-1:0]   d_src_b;
   logic [rv_isa_pkg::data_width-1:0]   d_imm;
   logic [3:0]                          d_br_kind;
   logic                                d_res_sel;
   logic                                d_we;

   function automatic logic [ex_pkg::alu_op_width-1:0] alu_sel(input logic [2:0] f3,
                                                               input logic alt_f);
      logic [ex_pkg::alu_op_width-1:0] op;
      op = '0;
      case (f3)
         rv_isa_pkg::f3_add:  op[alt_f ? ex_pkg::op_sub : ex_pkg::op_add] = 1'b1;
         rv_isa_pkg::f3_sll:  op[ex_pkg::op_sll] = 1'b1;
         rv_isa_pkg::f3_slt:  op[ex_pkg::op_slt] = 1'b1;
         rv_isa_pkg::f3_sltu: op[ex_pkg::op_sltu] = 1'b1;
         rv_isa_pkg::f3_xor:  op[ex_pkg::op_xor] = 1'b1;
         rv_isa_pkg::f3_sr:   op[alt_f ? ex_pkg::op_sra : ex_pkg::op_srl] = 1'b1;
         rv_isa_pkg::f3_or:   op[ex_pkg::op_or] = 1'b1;
         default:             op[ex_pkg::op_and] = 1'b1;
      endcase
      return op;
   endfunction

   assign opcode = instr[6:0];
   assign funct3 = instr[14:12];
   assign alt    = (instr[31:25] == rv_isa_pkg::f7_alt);
   assign imm_i  = {{20{instr[31]}}, instr[31:20]};
   assign imm_u  = {instr[31:12], 12'b0};
   assign imm_b  = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
   assign imm_j  = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

   always_comb begin
      d_alu_op  = '0;
      d_src_a   = rs1_data;
      d_imm     = imm_i;
      d_src_b   = imm_i;
      d_br_kind = ex_pkg::br_none;
      d_res_sel = ex_pkg::res_alu;
      d_we      = 1'b0;
      case (opcode)
         rv_isa_pkg::opc_op: begin
            d_src_b  = rs2_data;
            d_alu_op = alu_sel(funct3, alt);
            d_we     = 1'b1;
         end
         rv_isa_pkg::opc_op_imm: begin
            d_alu_op = alu_sel(funct3, alt & (funct3 == rv_isa_pkg::f3_sr)); // no subi
            d_we     = 1'b1;
         end
         rv_isa_pkg::opc_lui: begin
            d_src_a  = '0;
            d_imm    = imm_u;
            d_src_b  = imm_u;
            d_alu_op = alu_sel(rv_isa_pkg::f3_add, 1'b0);
            d_we     = 1'b1;
         end
         rv_isa_pkg::opc_auipc: begin
            d_src_a  = pc;
            d_imm    = imm_u;
            d_src_b  = imm_u;
            d_alu_op = alu_sel(rv_isa_pkg::f3_add, 1'b0);
            d_we     = 1'b1;
         end
         rv_isa_pkg::opc_branch: begin
            d_imm   = imm_b;
            d_src_b = imm_b;
            case (funct3)
               rv_isa_pkg::f3_beq:  d_br_kind = ex_pkg::br_eq;
               rv_isa_pkg::f3_bne:  d_br_kind = ex_pkg::br_ne;
               rv_isa_pkg::f3_blt:  d_br_kind = ex_pkg::br_lt;
               rv_isa_pkg::f3_bge:  d_br_kind = ex_pkg::br_ge;
               rv_isa_pkg::f3_bltu: d_br_kind = ex_pkg::br_ltu;
               rv_isa_pkg::f3_bgeu: d_br_kind = ex_pkg::br_geu;
               default:             d_br_kind = ex_pkg::br_none;
            endcase
         end
         rv_isa_pkg::opc_jal: begin
            d_src_a   = pc;
            d_imm     = imm_j;
            d_src_b   = imm_j;
            d_alu_op  = alu_sel(rv_isa_pkg::f3_add, 1'b0);
            d_br_kind = ex_pkg::br_jal;
            d_res_sel = ex_pkg::res_link;
            d_we      = 1'b1;
         end
         rv_isa_pkg::opc_jalr: begin
            d_alu_op  = alu_sel(rv_isa_pkg::f3_add, 1'b0);
            d_br_kind = ex_pkg::br_jalr;
            d_res_sel = ex_pkg::res_link;
            d_we      = 1'b1;
         end
         default: begin
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         uop.valid   <= 1'b0;
         uop.rd_we   <= 1'b0;
         uop.alu_op  <= '0;
         uop.br_kind <= ex_pkg::br_none;
      end else begin
         uop.valid   <= in_valid;
         uop.rd_we   <= d_we & (instr[11:7] != 5'd0); // x0 is never written
         uop.alu_op  <= d_alu_op;
         uop.br_kind <= d_br_kind;
      end
      uop.src_a   <= d_src_a;
      uop.src_b   <= d_src_b;
      uop.rs1_val <= rs1_data;
      uop.rs2_val <= rs2_data;
      uop.pc      <= pc;
      uop.imm     <= d_imm;
      uop.res_sel <= d_res_sel;
      uop.rd      <= instr[11:7];
   end

endmodule

// File: logic/alu.sv
`timescale 1ns/1ps

module alu (
   uop_if.alu                                 uop,
   output logic [rv_isa_pkg::data_width-1:0]  alu_result
);

   localparam int dw = rv_isa_pkg::data_width;
   localparam int aw = rv_isa_pkg::adder_width;

   logic          op_add, op_sub, op_xor, op_sll, op_srl, op_sra;
   logic          op_or, op_and, op_slt, op_sltu;
   logic          op_shift, adder_sub, op_addsub, slt_lt;
   logic [aw-1:0] adder_op1, adder_op2, adder_in1, adder_in2, adder_res;
   logic [dw-1:0] shifter_in1, shifter_res, srl_res, sra_res, sra_mask, slt_res;
   logic [4:0]    shamt;

   function automatic logic [dw-1:0] bit_rev(input logic [dw-1:0] v);
      logic [dw-1:0] r;
      for (int i = 0; i < dw; i++) begin
         r[i] = v[dw-1-i];
      end
      return r;
   endfunction

   assign op_add  = uop.alu_op[ex_pkg::op_add];
   assign op_sub  = uop.alu_op[ex_pkg::op_sub];
   assign op_xor  = uop.alu_op[ex_pkg::op_xor];
   assign op_sll  = uop.alu_op[ex_pkg::op_sll];
   assign op_srl  = uop.alu_op[ex_pkg::op_srl];
   assign op_sra  = uop.alu_op[ex_pkg::op_sra];
   assign op_or   = uop.alu_op[ex_pkg::op_or];
   assign op_and  = uop.alu_op[ex_pkg::op_and];
   assign op_slt  = uop.alu_op[ex_pkg::op_slt];
   assign op_sltu = uop.alu_op[ex_pkg::op_sltu];

   assign adder_sub = op_sub | op_slt | op_sltu; // compares subtract too
   assign op_addsub = op_add | adder_sub;
   assign op_shift  = op_sll | op_srl | op_sra;

   // sign-extend both operands unless the compare is unsigned
   assign adder_op1 = {{(aw-dw){~op_sltu & uop.src_a[dw-1]}}, uop.src_a};
   assign adder_op2 = {{(aw-dw){~op_sltu & uop.src_b[dw-1]}}, uop.src_b};
   assign adder_in1 = {aw{op_addsub}} & adder_op1;
   assign adder_in2 = {aw{op_addsub}} & (adder_sub ? ~adder_op2 : adder_op2);
   assign adder_res = adder_in1 + adder_in2 + {{(aw-1){1'b0}}, adder_sub};

   assign slt_lt  = adder_res[aw-1]; // negative difference means less than
   assign slt_res = {{(dw-1){1'b0}}, slt_lt};

   // right shifts go through the left shifter on reversed bits
   assign shamt       = {5{op_shift}} & uop.src_b[4:0];
   assign shifter_in1 = {dw{op_shift}} &
                        ((op_srl | op_sra) ? bit_rev(uop.src_a) : uop.src_a);
   assign shifter_res = shifter_in1 << shamt;
   assign srl_res     = bit_rev(shifter_res);

   assign sra_mask = {dw{1'b1}} >> shamt;
   assign sra_res  = (srl_res & sra_mask) | ({dw{uop.src_a[dw-1]}} & ~sra_mask);

   assign alu_result = ({dw{op_add | op_sub}}  & adder_res[dw-1:0]) |
                       ({dw{op_xor}}        & (uop.src_a ^ uop.src_b)) |
                       ({dw{op_sll}}        & shifter_res) |
                       ({dw{op_srl}}        & srl_res) |
                       ({dw{op_sra}}        & sra_res) |
                       ({dw{op_or}}         & (uop.src_a | uop.src_b)) |
                       ({dw{op_and}}        & (uop.src_a & uop.src_b)) |
                       ({dw{op_slt | op_sltu}} & slt_res);

endmodule

// File: logic/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
   uop_if.br                                  uop,
   output logic                               taken,
   output logic [rv_isa_pkg::data_width-1:0]  target,
   output logic [rv_isa_pkg::data_width-1:0]  link
);

   logic                              eq, lt, ltu;
   logic [rv_isa_pkg::data_width-1:0] jalr_sum;

   assign eq  = (uop.rs1_val == uop.rs2_val);
   assign lt  = ($signed(uop.rs1_val) < $signed(uop.rs2_val));
   assign ltu = (uop.rs1_val < uop.rs2_val);

   always_comb begin
      case (uop.br_kind)
         ex_pkg::br_eq:   taken = eq;
         ex_pkg::br_ne:   taken = ~eq;
         ex_pkg::br_lt:   taken = lt;
         ex_pkg::br_ge:   taken = ~lt;
         ex_pkg::br_ltu:  taken = ltu;
         ex_pkg::br_geu:  taken = ~ltu;
         ex_pkg::br_jal,
         ex_pkg::br_jalr: taken = 1'b1;
         default:         taken = 1'b0;
      endcase
   end

   assign jalr_sum = uop.rs1_val + uop.imm;
   assign target   = (uop.br_kind == ex_pkg::br_jalr) ?
                     {jalr_sum[rv_isa_pkg::data_width-1:1], 1'b0} : uop.pc + uop.imm;
   assign link     = uop.pc + 32'd4; // return address

endmodule

// File: logic/ex_writeback.sv
`timescale 1ns/1ps

module ex_writeback (
   input  logic                              clk,
   input  logic                              reset,
   uop_if.wb                                 uop,
   input  logic [rv_isa_pkg::data_width-1:0] alu_result,
   input  logic [rv_isa_pkg::data_width-1:0] link,
   input  logic [rv_isa_pkg::data_width-1:0] target,
   input  logic                              taken,
   output logic                              out_valid,
   output logic                              rd_we,
   output logic                              br_taken,
   output logic [4:0]                        rd,
   output logic [rv_isa_pkg::data_width-1:0] rd_data,
   output logic [rv_isa_pkg::data_width-1:0] br_target
);

   logic [rv_isa_pkg::data_width-1:0] wb_data;

   assign wb_data = (uop.res_sel == ex_pkg::res_link) ? link : alu_result;

   always_ff @(posedge clk) begin
      if (reset) begin
         out_valid <= 1'b0;
         rd_we     <= 1'b0;
         br_taken  <= 1'b0;
      end else begin
         out_valid <= uop.valid;
         rd_we     <= uop.valid & uop.rd_we;
         br_taken  <= uop.valid & taken;
      end
      rd        <= uop.rd;
      rd_data   <= wb_data;
      br_target <= target;
   end

endmodule

// File: logic/ex_unit.sv
`timescale 1ns/1ps

module ex_unit (
   input  logic                              clk,
   input  logic                              reset,
   input  logic                              in_valid,
   input  logic [31:0]                       instr,
   input  logic [rv_isa_pkg::data_width-1:0] pc,
   input  logic [rv_isa_pkg::data_width-1:0] rs1_data,
   input  logic [rv_isa_pkg::data_width-1:0] rs2_data,
   output logic                              out_valid,
   output logic [4:0]                        rd,
   output logic                              rd_we,
   output logic [rv_isa_pkg::data_width-1:0] rd_data,
   output logic                              br_taken,
   output logic [rv_isa_pkg::data_width-1:0] br_target
);

   uop_if u_uop ();

   logic [rv_isa_pkg::data_width-1:0] alu_result;
   logic [rv_isa_pkg::data_width-1:0] target;
   logic [rv_isa_pkg::data_width-1:0] link;
   logic                              taken;

   ex_decoder u_dec (
      .clk(clk), .reset(reset), .in_valid(in_valid), .instr(instr), .pc(pc),
      .rs1_data(rs1_data), .rs2_data(rs2_data), .uop(u_uop.dec)
   );

   alu u_alu (.uop(u_uop.alu), .alu_result(alu_result));

   branch_unit u_br (.uop(u_uop.br), .taken(taken), .target(target), .link(link));

   ex_writeback u_wb (
      .clk(clk), .reset(reset), .uop(u_uop.wb), .alu_result(alu_result), .link(link),
      .target(target), .taken(taken), .out_valid(out_valid), .rd_we(rd_we),
      .br_taken(br_taken), .rd(rd), .rd_data(rd_data), .br_target(br_target)
   );

endmodule

// File: dv/ex_unit_checker.sv
`timescale 1ns/1ps

module ex_unit_checker (
   input logic                              clk,
   input logic                              reset,
   input logic                              in_valid,
   input logic                              out_valid,
   input logic [4:0]                        rd,
   input logic                              rd_we,
   input logic [rv_isa_pkg::data_width-1:0] rd_data,
   input logic                              br_taken
);

   int error_count = 0; // read by the testbench

   a_latency: assert property (@(posedge clk) disable iff (reset)
      out_valid == $past(in_valid, 2))
   else begin
      error_count = error_count + 1;
      $error("out_valid does not follow in_valid by two cycles");
   end

   a_qualified: assert property (@(posedge clk) disable iff (reset)
      (rd_we || br_taken) |-> out_valid)
   else begin
      error_count = error_count + 1;
      $error("rd_we or br_taken high without out_valid");
   end

   a_no_x0: assert property (@(posedge clk) disable iff (reset)
      rd_we |-> (rd != 5'd0))
   else begin
      error_count = error_count + 1;
      $error("write to x0");
   end

   a_known_data: assert property (@(posedge clk) disable iff (reset)
      rd_we |-> !$isunknown(rd_data))
   else begin
      error_count = error_count + 1;
      $error("rd_data unknown during a write");
   end

endmodule

// File: dv/ex_unit_tb.sv
`timescale 1ns/1ps

module ex_unit_tb;

   localparam int max_vecs     = 64;
   localparam int vec_words    = 9; // instr pc rs1 rs2 we rd data taken target
   localparam int half_period  = 20;
   localparam int reset_cycles = 10;

   typedef struct packed {
      logic [31:0] instr;
      logic        rd_we;
      logic [4:0]  rd;
      logic [31:0] rd_data;
      logic        br_taken;
      logic [31:0] br_target;
   } expect_t;

   logic                              clk;
   logic                              reset;
   logic                              in_valid;
   logic [31:0]                       instr;
   logic [rv_isa_pkg::data_width-1:0] pc;
   logic [rv_isa_pkg::data_width-1:0] rs1_data;
   logic [rv_isa_pkg::data_width-1:0] rs2_data;
   logic                              out_valid;
   logic [4:0]                        rd;
   logic                              rd_we;
   logic [rv_isa_pkg::data_width-1:0] rd_data;
   logic                              br_taken;
   logic [rv_isa_pkg::data_width-1:0] br_target;

   logic [31:0] vec_mem [0:max_vecs*vec_words-1];
   expect_t     exp_q[$]; // in-flight instructions, oldest first
   int          num_vecs;
   int          out_count;
   int          timeout_cycles;

   ex_unit dut (
      .clk(clk), .reset(reset), .in_valid(in_valid), .instr(instr), .pc(pc),
      .rs1_data(rs1_data), .rs2_data(rs2_data), .out_valid(out_valid), .rd(rd),
      .rd_we(rd_we), .rd_data(rd_data), .br_taken(br_taken), .br_target(br_target)
   );

   bind ex_unit ex_unit_checker u_chk (
      .clk(clk), .reset(reset), .in_valid(in_valid), .out_valid(out_valid),
      .rd(rd), .rd_we(rd_we), .rd_data(rd_data), .br_taken(br_taken)
   );

   always #(half_period) clk = ~clk;

   task automatic stop_with_failure(input string reason);
      $display("%s", reason);
      $display("TB FAILED");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check_value(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
      if (actual !== expected) begin
         stop_with_failure($sformatf("FAIL %s: got 0x%08h, expected 0x%08h",
                                     name, actual, expected));
      end
   endtask

   // outputs are sampled at the edge, before the DUT updates them
   always @(posedge clk) begin
      expect_t e;
      string   tag;
      if (dut.u_chk.error_count != 0) begin
         stop_with_failure("a concurrent assertion in the checker failed");
      end
      if (!reset && out_valid === 1'b1) begin
         if (exp_q.size() == 0) begin
            stop_with_failure("out_valid was high with no instruction in flight");
         end else begin
            e   = exp_q.pop_front();
            tag = $sformatf(" of vector %0d", out_count);
            check_value({"rd_we", tag}, {31'b0, rd_we}, {31'b0, e.rd_we});
            check_value({"br_taken", tag}, {31'b0, br_taken}, {31'b0, e.br_taken});
            if (e.rd_we) begin
               check_value({"rd", tag}, {27'b0, rd}, {27'b0, e.rd});
               check_value({"rd_data", tag}, rd_data, e.rd_data);
            end
            if (e.instr[6:4] == 3'b110) begin // branch, jal and jalr
               check_value({"br_target", tag}, br_target, e.br_target);
            end
            out_count = out_count + 1;
         end
      end
   end

   initial begin
      expect_t e;
      int      base;
      int      idle;
      void'($urandom(35));
      clk       = 1'b0;
      reset     = 1'b1;
      in_valid  = 1'b0;
      instr     = '0;
      pc        = '0;
      rs1_data  = '0;
      rs2_data  = '0;
      out_count = 0;
      $readmemh("dv/ex_tests.txt", vec_mem);
      num_vecs = 0;
      while (num_vecs < max_vecs && vec_mem[num_vecs*vec_words] != 32'h0) begin
         num_vecs = num_vecs + 1; // a zero instr word ends the list
      end
      timeout_cycles = num_vecs * 4 + 100;

      repeat (reset_cycles) @(posedge clk);
      reset <= 1'b0;

      for (int v = 0; v < num_vecs; v++) begin
         base = v * vec_words;
         idle = $urandom % 3;
         repeat (idle) begin
            @(posedge clk);
            in_valid <= 1'b0;
         end
         @(posedge clk);
         in_valid    <= 1'b1;
         instr       <= vec_mem[base];
         pc          <= vec_mem[base+1];
         rs1_data    <= vec_mem[base+2];
         rs2_data    <= vec_mem[base+3];
         e.instr     = vec_mem[base];
         e.rd_we     = vec_mem[base+4][0];
         e.rd        = vec_mem[base+5][4:0];
         e.rd_data   = vec_mem[base+6];
         e.br_taken  = vec_mem[base+7][0];
         e.br_target = vec_mem[base+8];
         exp_q.push_back(e);
      end
      @(posedge clk);
      in_valid <= 1'b0;

      while (exp_q.size() != 0) begin
         @(posedge clk);
      end
      repeat (3) @(posedge clk); // let the latency assertion see the tail

      if (num_vecs == 0 || out_count != num_vecs || dut.u_chk.error_count != 0) begin
         stop_with_failure($sformatf("run incomplete: %0d of %0d results, %0d assertion errors",
                                     out_count, num_vecs, dut.u_chk.error_count));
      end else begin
         $display("TB PASSED");
         $finish;
      end
   end

   // watchdog
   initial begin
      wait (timeout_cycles > 0);
      repeat (timeout_cycles) @(posedge clk);
      stop_with_failure($sformatf("timeout: outputs stopped arriving within %0d cycles",
                                  timeout_cycles));
   end

endmodule

// File: dv/ex_tests.txt
// columns: instr pc rs1 rs2, then expected rd_we rd rd_data br_taken br_target
// a row whose instr is 00000000 ends the list
002081B3 00001000 FFFFFFFF 00000002 1 03 00000001 0 00000000 // add, carry out
402081B3 00001004 00000001 00000002 1 03 FFFFFFFF 0 00000000 // sub, borrow
0020C1B3 00001008 F0F0F0F0 FF00FF00 1 03 0FF00FF0 0 00000000 // xor
0020E1B3 0000100C F0F0F0F0 0F0000FF 1 03 FFF0F0FF 0 00000000 // or
0020F1B3 00001010 F0F0F0F0 FF00FF00 1 03 F000F000 0 00000000 // and
FFF08193 00001014 80000000 00000000 1 03 7FFFFFFF 0 00000000 // addi -1
7FF0C193 00001018 12345678 00000000 1 03 12345187 0 00000000 // xori 0x7ff
F0F0F193 0000101C 12345678 00000000 1 03 12345608 0 00000000 // andi, negative imm
0020A1B3 00001020 80000000 00000001 1 03 00000001 0 00000000 // slt
0020B1B3 00001024 80000000 00000001 1 03 00000000 0 00000000 // sltu
00009193 00001028 80000001 00000000 1 03 80000001 0 00000000 // slli 0
00109193 0000102C 80000001 00000000 1 03 00000002 0 00000000 // slli 1
01F0D193 00001030 80000000 00000000 1 03 00000001 0 00000000 // srli 31
41F0D193 00001034 80000000 00000000 1 03 FFFFFFFF 0 00000000 // srai 31
4010D193 00001038 80000010 00000000 1 03 C0000008 0 00000000 // srai 1
002091B3 0000103C 00000001 0000003F 1 03 80000000 0 00000000 // sll by 63
0020D1B3 00001040 80000000 00000021 1 03 40000000 0 00000000 // srl by 33
4020D1B3 00001044 F0000000 00000024 1 03 FF000000 0 00000000 // sra by 36
123451B7 00001048 00000000 00000000 1 03 12345000 0 00000000 // lui
FFFFF197 00002000 00000000 00000000 1 03 00001000 0 00000000 // auipc, wraps
00208863 00000100 00000005 00000005 0 00 00000000 1 00000110 // beq taken
FE208CE3 00000100 00000005 00000006 0 00 00000000 0 000000F8 // beq not taken
00209863 00000100 00000005 00000006 0 00 00000000 1 00000110 // bne taken
FE209CE3 00000100 00000005 00000005 0 00 00000000 0 000000F8 // bne not taken
0020C863 00000100 FFFFFFFF 00000001 0 00 00000000 1 00000110 // blt taken
FE20CCE3 00000100 00000001 FFFFFFFF 0 00 00000000 0 000000F8 // blt not taken
0020D863 00000100 00000001 FFFFFFFF 0 00 00000000 1 00000110 // bge taken
FE20DCE3 00000100 FFFFFFFF 00000001 0 00 00000000 0 000000F8 // bge not taken
0020E863 00000100 00000001 FFFFFFFF 0 00 00000000 1 00000110 // bltu taken
FE20ECE3 00000100 FFFFFFFF 00000001 0 00 00000000 0 000000F8 // bltu not taken
0020F863 00000100 80000000 80000000 0 00 00000000 1 00000110 // bgeu taken, equal
FE20FCE3 00000100 00000001 80000000 0 00 00000000 0 000000F8 // bgeu not taken
100000EF 00000200 00000000 00000000 1 01 00000204 1 00000300 // jal x1
003280E7 00000400 00001000 00000000 1 01 00000404 1 00001002 // jalr, bit 0 cleared
FFDFF06F 00000500 00000000 00000000 0 00 00000000 1 000004FC // jal x0
0FF0000F 00000600 00000000 00000000 0 00 00000000 0 00000000 // fence passes through
00000000 00000000 00000000 00000000 0 00 00000000 0 00000000 // end

// File: tb.f
logic/rv_isa_pkg.sv
logic/ex_pkg.sv
logic/uop_if.sv
logic/ex_decoder.sv
logic/alu.sv
logic/branch_unit.sv
logic/ex_writeback.sv
logic/ex_unit.sv
dv/ex_unit_checker.sv
dv/ex_unit_tb.sv

// File: Makefile
SIM     ?= verilator
TOP     ?= ex_unit_tb
LOG     ?= sim.log
OBJ_DIR ?= obj_dir
VFLAGS  ?= --binary --assert -j 0
RUNARGS ?= +verilator+error+limit+100

BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f tb.f

run: build
	-$(BIN) $(RUNARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "TB PASSED" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(SIM) --lint-only -Wall --timing --assert --top-module $(TOP) -f tb.f

clean:
	rm -rf $(OBJ_DIR) $(LOG)
